//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [15:0] word_t;
	typedef logic [1:0] reg_idx_t;

	localparam int NUM_REGS = 4;

	// opcode field values
	localparam logic [3:0] OP_ADI = 4'd4;
	localparam logic [3:0] OP_ORI = 4'd5;
	localparam logic [3:0] OP_LHI = 4'd6;
	localparam logic [3:0] OP_LWD = 4'd7;
	localparam logic [3:0] OP_SWD = 4'd8;
	localparam logic [3:0] OP_RTYPE = 4'd15;

	// func field of r-type words
	localparam logic [5:0] FN_ADD = 6'd0;
	localparam logic [5:0] FN_SUB = 6'd1;
	localparam logic [5:0] FN_AND = 6'd2;
	localparam logic [5:0] FN_ORR = 6'd3;
	localparam logic [5:0] FN_NOT = 6'd4;
	localparam logic [5:0] FN_TCP = 6'd5;
	localparam logic [5:0] FN_SHL = 6'd6;
	localparam logic [5:0] FN_SHR = 6'd7;
	localparam logic [5:0] FN_WWD = 6'd28;
	localparam logic [5:0] FN_HLT = 6'd29;

	// first eight codes line up with FN_ADD..FN_SHR
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_ORR = 4'd3,
		ALU_NOT = 4'd4,
		ALU_TCP = 4'd5,
		ALU_SHL = 4'd6,
		ALU_SHR = 4'd7,
		ALU_PASSB = 4'd8
	} alu_op_t;

	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			reg_idx_t rs;
			reg_idx_t rt;
			reg_idx_t rd;
			logic [5:0] func;
		} r;
		struct packed {
			logic [3:0] opcode;
			reg_idx_t rs;
			reg_idx_t rt;
			logic [7:0] imm;
		} i;
	} instr_u;

endpackage

`default_nettype wire

//--- hw/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage import cpu_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input  logic   clk,
	input  logic   reset_n,
	input  logic   hold_i,
	input  word_t  inst_data_i,
	output logic   inst_read_o,
	output word_t  inst_addr_o,
	output logic   if_valid_o,
	output instr_u if_instr_o,
	output word_t  if_pc_o
);

	word_t pc;
	logic run;

	// run comes up one cycle after reset is released
	assign inst_read_o = run & ~hold_i;
	assign inst_addr_o = pc;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			run <= 1'b0;
			pc <= RESET_PC;
			if_valid_o <= 1'b0;
		end else begin
			run <= 1'b1;
			if (inst_read_o) begin
				pc <= pc + 16'd1;
				if_valid_o <= 1'b1;
			end
		end
	end

	// IF/ID payload, frozen while decode holds
	always_ff @(posedge clk) begin
		if (inst_read_o) begin
			if_instr_o <= instr_u'(inst_data_i);
			if_pc_o <= pc;
		end
	end

endmodule

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file import cpu_pkg::*; (
	input  logic     clk,
	input  logic     reset_n,
	input  reg_idx_t rd_a_i,
	input  reg_idx_t rd_b_i,
	input  logic     we_i,
	input  reg_idx_t wr_idx_i,
	input  word_t    wr_data_i,
	output word_t    rd_a_o,
	output word_t    rd_b_o
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i) begin
			regs[wr_idx_i] <= wr_data_i;
		end
	end

	// write-through so WB and ID can share a cycle
	assign rd_a_o = (we_i && wr_idx_i == rd_a_i) ? wr_data_i : regs[rd_a_i];
	assign rd_b_o = (we_i && wr_idx_i == rd_b_i) ? wr_data_i : regs[rd_b_i];

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage import cpu_pkg::*; (
	input  logic     clk,
	input  logic     reset_n,
	input  logic     if_valid_i,
	input  instr_u   if_instr_i,
	input  logic     wb_we_i,
	input  reg_idx_t wb_dest_i,
	input  word_t    wb_data_i,
	output logic     hold_o,
	output logic     id_valid_o,
	output word_t    id_a_o,
	output word_t    id_b_o,
	output word_t    id_imm_o,
	output reg_idx_t id_rs_o,
	output reg_idx_t id_rt_o,
	output reg_idx_t id_dest_o,
	output alu_op_t  id_alu_op_o,
	output logic     id_src_imm_o,
	output logic     id_we_o,
	output logic     id_mem_read_o,
	output logic     id_mem_write_o,
	output logic     id_wwd_o,
	output logic     id_halt_o
);

	reg_idx_t rs;
	reg_idx_t rt;
	logic [7:0] imm8;
	word_t rf_a;
	word_t rf_b;
	logic dec_known;
	logic dec_we;
	logic dec_mem_read;
	logic dec_mem_write;
	logic dec_wwd;
	logic dec_halt;
	logic dec_src_imm;
	logic uses_rs;
	logic uses_rt;
	reg_idx_t dec_dest;
	word_t dec_imm;
	alu_op_t dec_alu_op;
	logic dec_valid;
	logic load_use;
	logic issue;
	logic halt_seen;

	assign rs = if_instr_i.r.rs;
	assign rt = if_instr_i.r.rt;
	assign imm8 = if_instr_i.i.imm;

	register_file u_regs (
		.clk       (clk),
		.reset_n   (reset_n),
		.rd_a_i    (rs),
		.rd_b_i    (rt),
		.we_i      (wb_we_i),
		.wr_idx_i  (wb_dest_i),
		.wr_data_i (wb_data_i),
		.rd_a_o    (rf_a),
		.rd_b_o    (rf_b)
	);

	// defaults describe a sign-extended i-type reading rs
	always_comb begin
		dec_known = 1'b0;
		dec_we = 1'b0;
		dec_mem_read = 1'b0;
		dec_mem_write = 1'b0;
		dec_wwd = 1'b0;
		dec_halt = 1'b0;
		dec_src_imm = 1'b1;
		uses_rs = 1'b1;
		uses_rt = 1'b0;
		dec_dest = rt;
		dec_imm = {{8{imm8[7]}}, imm8};
		dec_alu_op = ALU_ADD;
		case (if_instr_i.r.opcode)
			OP_ADI: begin
				dec_known = 1'b1;
				dec_we = 1'b1;
			end
			OP_ORI: begin
				dec_known = 1'b1;
				dec_we = 1'b1;
				dec_alu_op = ALU_ORR;
				dec_imm = {8'h00, imm8};
			end
			OP_LHI: begin
				dec_known = 1'b1;
				dec_we = 1'b1;
				uses_rs = 1'b0;
				dec_alu_op = ALU_PASSB;
				dec_imm = {imm8, 8'h00};
			end
			OP_LWD: begin
				dec_known = 1'b1;
				dec_we = 1'b1;
				dec_mem_read = 1'b1;
			end
			OP_SWD: begin
				dec_known = 1'b1;
				dec_mem_write = 1'b1;
				uses_rt = 1'b1;
			end
			OP_RTYPE: begin
				dec_src_imm = 1'b0;
				dec_dest = if_instr_i.r.rd;
				dec_alu_op = alu_op_t'(if_instr_i.r.func[3:0]);
				case (if_instr_i.r.func)
					FN_ADD, FN_SUB, FN_AND, FN_ORR: begin
						dec_known = 1'b1;
						dec_we = 1'b1;
						uses_rt = 1'b1;
					end
					FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
						dec_known = 1'b1;
						dec_we = 1'b1;
					end
					FN_WWD: begin
						dec_known = 1'b1;
						dec_wwd = 1'b1;
					end
					FN_HLT: begin
						dec_known = 1'b1;
						dec_halt = 1'b1;
						uses_rs = 1'b0;
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	assign dec_valid = if_valid_i & dec_known;

	// load in ID/EX feeding the word now in ID
	assign load_use = dec_valid & id_valid_o & id_mem_read_o &
		((uses_rs & (id_dest_o == rs)) | (uses_rt & (id_dest_o == rt)));
	assign issue = dec_valid & ~load_use & ~halt_seen;
	assign hold_o = halt_seen | load_use | (dec_valid & dec_halt);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			id_valid_o <= 1'b0;
			id_we_o <= 1'b0;
			id_mem_read_o <= 1'b0;
			id_mem_write_o <= 1'b0;
			id_wwd_o <= 1'b0;
			id_halt_o <= 1'b0;
			halt_seen <= 1'b0;
		end else begin
			id_valid_o <= issue;
			id_we_o <= issue & dec_we;
			id_mem_read_o <= issue & dec_mem_read;
			id_mem_write_o <= issue & dec_mem_write;
			id_wwd_o <= issue & dec_wwd;
			id_halt_o <= issue & dec_halt;
			if (issue && dec_halt) begin
				halt_seen <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		id_a_o <= rf_a;
		id_b_o <= rf_b;
		id_imm_o <= dec_imm;
		id_rs_o <= rs;
		id_rt_o <= rt;
		id_dest_o <= dec_dest;
		id_alu_op_o <= dec_alu_op;
		id_src_imm_o <= dec_src_imm;
	end

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage import cpu_pkg::*; (
	input  logic     clk,
	input  logic     reset_n,
	input  logic     id_valid_i,
	input  word_t    id_a_i,
	input  word_t    id_b_i,
	input  word_t    id_imm_i,
	input  reg_idx_t id_rs_i,
	input  reg_idx_t id_rt_i,
	input  reg_idx_t id_dest_i,
	input  alu_op_t  id_alu_op_i,
	input  logic     id_src_imm_i,
	input  logic     id_we_i,
	input  logic     id_mem_read_i,
	input  logic     id_mem_write_i,
	input  logic     id_wwd_i,
	input  logic     id_halt_i,
	input  logic     wb_we_i,
	input  reg_idx_t wb_dest_i,
	input  word_t    wb_data_i,
	output logic     ex_valid_o,
	output word_t    ex_result_o,
	output word_t    ex_store_o,
	output reg_idx_t ex_dest_o,
	output logic     ex_we_o,
	output logic     ex_mem_read_o,
	output logic     ex_mem_write_o,
	output logic     ex_wwd_o,
	output logic     ex_halt_o
);

	logic ex_fwd_ok;
	word_t fwd_a;
	word_t fwd_b;
	word_t alu_b;
	word_t alu_y;

	// a load result is not ready in EX/MEM, the stall covers that case
	assign ex_fwd_ok = ex_valid_o & ex_we_o & ~ex_mem_read_o;

	assign fwd_a = (ex_fwd_ok && ex_dest_o == id_rs_i) ? ex_result_o :
		(wb_we_i && wb_dest_i == id_rs_i) ? wb_data_i : id_a_i;
	assign fwd_b = (ex_fwd_ok && ex_dest_o == id_rt_i) ? ex_result_o :
		(wb_we_i && wb_dest_i == id_rt_i) ? wb_data_i : id_b_i;

	assign alu_b = id_src_imm_i ? id_imm_i : fwd_b;

	always_comb begin
		case (id_alu_op_i)
			ALU_ADD: alu_y = fwd_a + alu_b;
			ALU_SUB: alu_y = fwd_a - alu_b;
			ALU_AND: alu_y = fwd_a & alu_b;
			ALU_ORR: alu_y = fwd_a | alu_b;
			ALU_NOT: alu_y = ~fwd_a;
			ALU_TCP: alu_y = ~fwd_a + 16'd1;
			ALU_SHL: alu_y = {fwd_a[14:0], 1'b0};
			// arithmetic, sign bit kept
			ALU_SHR: alu_y = {fwd_a[15], fwd_a[15:1]};
			ALU_PASSB: alu_y = alu_b;
			default: alu_y = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ex_valid_o <= 1'b0;
			ex_we_o <= 1'b0;
			ex_mem_read_o <= 1'b0;
			ex_mem_write_o <= 1'b0;
			ex_wwd_o <= 1'b0;
			ex_halt_o <= 1'b0;
		end else begin
			ex_valid_o <= id_valid_i;
			ex_we_o <= id_we_i;
			ex_mem_read_o <= id_mem_read_i;
			ex_mem_write_o <= id_mem_write_i;
			ex_wwd_o <= id_wwd_i;
			ex_halt_o <= id_halt_i;
		end
	end

	// wwd sends rs through as its result
	always_ff @(posedge clk) begin
		ex_result_o <= id_wwd_i ? fwd_a : alu_y;
		ex_store_o <= fwd_b;
		ex_dest_o <= id_dest_i;
	end

endmodule

`default_nettype wire

//--- hw/mem_wb_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage import cpu_pkg::*; (
	input  logic     clk,
	input  logic     reset_n,
	input  logic     ex_valid_i,
	input  word_t    ex_result_i,
	input  word_t    ex_store_i,
	input  reg_idx_t ex_dest_i,
	input  logic     ex_we_i,
	input  logic     ex_mem_read_i,
	input  logic     ex_mem_write_i,
	input  logic     ex_wwd_i,
	input  logic     ex_halt_i,
	input  word_t    data_rd_i,
	output logic     data_read_o,
	output logic     data_write_o,
	output word_t    data_addr_o,
	output word_t    data_wr_o,
	output logic     wb_we_o,
	output reg_idx_t wb_dest_o,
	output word_t    wb_data_o,
	output word_t    num_inst_o,
	output word_t    output_port_o,
	output logic     is_halted_o
);

	logic wb_valid;
	logic wb_wwd;
	logic wb_halt;

	// decode never flags a word as both load and store
	assign data_read_o = ex_mem_read_i;
	assign data_write_o = ex_mem_write_i;
	assign data_addr_o = ex_result_i;
	assign data_wr_o = ex_store_i;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wb_valid <= 1'b0;
			wb_we_o <= 1'b0;
			wb_wwd <= 1'b0;
			wb_halt <= 1'b0;
		end else begin
			wb_valid <= ex_valid_i;
			wb_we_o <= ex_we_i;
			wb_wwd <= ex_wwd_i;
			wb_halt <= ex_halt_i;
		end
	end

	always_ff @(posedge clk) begin
		wb_dest_o <= ex_dest_i;
		wb_data_o <= ex_mem_read_i ? data_rd_i : ex_result_i;
	end

	// retire side, visible once the word leaves WB
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			num_inst_o <= '0;
			output_port_o <= '0;
			is_halted_o <= 1'b0;
		end else if (wb_valid) begin
			num_inst_o <= num_inst_o + 16'd1;
			if (wb_wwd) begin
				output_port_o <= wb_data_o;
			end
			if (wb_halt) begin
				is_halted_o <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top import cpu_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input  logic  clk,
	input  logic  reset_n,
	output logic  inst_read_o,
	output word_t inst_addr_o,
	input  word_t inst_data_i,
	output logic  data_read_o,
	output logic  data_write_o,
	output word_t data_addr_o,
	output word_t data_wr_o,
	input  word_t data_rd_i,
	output word_t num_inst_o,
	output word_t output_port_o,
	output logic  is_halted_o
);

	logic hold;
	logic if_valid;
	instr_u if_instr;

	logic id_valid;
	word_t id_a;
	word_t id_b;
	word_t id_imm;
	reg_idx_t id_rs;
	reg_idx_t id_rt;
	reg_idx_t id_dest;
	alu_op_t id_alu_op;
	logic id_src_imm;
	logic id_we;
	logic id_mem_read;
	logic id_mem_write;
	logic id_wwd;
	logic id_halt;

	logic ex_valid;
	word_t ex_result;
	word_t ex_store;
	reg_idx_t ex_dest;
	logic ex_we;
	logic ex_mem_read;
	logic ex_mem_write;
	logic ex_wwd;
	logic ex_halt;

	logic wb_we;
	reg_idx_t wb_dest;
	word_t wb_data;

	// the fetch pc is kept in IF/ID but nothing downstream needs it yet
	fetch_stage #(
		.RESET_PC (RESET_PC)
	) u_fetch (
		.clk         (clk),
		.reset_n     (reset_n),
		.hold_i      (hold),
		.inst_data_i (inst_data_i),
		.inst_read_o (inst_read_o),
		.inst_addr_o (inst_addr_o),
		.if_valid_o  (if_valid),
		.if_instr_o  (if_instr),
		.if_pc_o     ()
	);

	decode_stage u_decode (
		.clk            (clk),
		.reset_n        (reset_n),
		.if_valid_i     (if_valid),
		.if_instr_i     (if_instr),
		.wb_we_i        (wb_we),
		.wb_dest_i      (wb_dest),
		.wb_data_i      (wb_data),
		.hold_o         (hold),
		.id_valid_o     (id_valid),
		.id_a_o         (id_a),
		.id_b_o         (id_b),
		.id_imm_o       (id_imm),
		.id_rs_o        (id_rs),
		.id_rt_o        (id_rt),
		.id_dest_o      (id_dest),
		.id_alu_op_o    (id_alu_op),
		.id_src_imm_o   (id_src_imm),
		.id_we_o        (id_we),
		.id_mem_read_o  (id_mem_read),
		.id_mem_write_o (id_mem_write),
		.id_wwd_o       (id_wwd),
		.id_halt_o      (id_halt)
	);

	execute_stage u_execute (
		.clk            (clk),
		.reset_n        (reset_n),
		.id_valid_i     (id_valid),
		.id_a_i         (id_a),
		.id_b_i         (id_b),
		.id_imm_i       (id_imm),
		.id_rs_i        (id_rs),
		.id_rt_i        (id_rt),
		.id_dest_i      (id_dest),
		.id_alu_op_i    (id_alu_op),
		.id_src_imm_i   (id_src_imm),
		.id_we_i        (id_we),
		.id_mem_read_i  (id_mem_read),
		.id_mem_write_i (id_mem_write),
		.id_wwd_i       (id_wwd),
		.id_halt_i      (id_halt),
		.wb_we_i        (wb_we),
		.wb_dest_i      (wb_dest),
		.wb_data_i      (wb_data),
		.ex_valid_o     (ex_valid),
		.ex_result_o    (ex_result),
		.ex_store_o     (ex_store),
		.ex_dest_o      (ex_dest),
		.ex_we_o        (ex_we),
		.ex_mem_read_o  (ex_mem_read),
		.ex_mem_write_o (ex_mem_write),
		.ex_wwd_o       (ex_wwd),
		.ex_halt_o      (ex_halt)
	);

	mem_wb_stage u_mem_wb (
		.clk            (clk),
		.reset_n        (reset_n),
		.ex_valid_i     (ex_valid),
		.ex_result_i    (ex_result),
		.ex_store_i     (ex_store),
		.ex_dest_i      (ex_dest),
		.ex_we_i        (ex_we),
		.ex_mem_read_i  (ex_mem_read),
		.ex_mem_write_i (ex_mem_write),
		.ex_wwd_i       (ex_wwd),
		.ex_halt_i      (ex_halt),
		.data_rd_i      (data_rd_i),
		.data_read_o    (data_read_o),
		.data_write_o   (data_write_o),
		.data_addr_o    (data_addr_o),
		.data_wr_o      (data_wr_o),
		.wb_we_o        (wb_we),
		.wb_dest_o      (wb_dest),
		.wb_data_o      (wb_data),
		.num_inst_o     (num_inst_o),
		.output_port_o  (output_port_o),
		.is_halted_o    (is_halted_o)
	);

endmodule

`default_nettype wire

//--- tests/cpu_sva.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_sva import cpu_pkg::*; (
	input logic  clk,
	input logic  reset_n,
	input logic  inst_read_i,
	input logic  data_read_i,
	input logic  data_write_i,
	input word_t num_inst_i,
	input logic  is_halted_i
);

	a_one_strobe: assert property (@(posedge clk) disable iff (!reset_n)
		!(data_read_i && data_write_i))
		else $error("data read and write strobes high in the same cycle");

	a_halt_sticky: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted_i |=> is_halted_i)
		else $error("is_halted_o fell without a reset");

	// nothing retires behind HLT
	a_count_frozen: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted_i |=> $stable(num_inst_i))
		else $error("num_inst_o moved while halted");

	a_fetch_reset: assert property (@(posedge clk)
		!reset_n |=> !inst_read_i)
		else $error("inst_read_o high right after a reset cycle");

endmodule

`default_nettype wire

//--- tests/cpu_checker.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_checker import cpu_pkg::*; (
	input  logic  clk,
	input  logic  reset_n,
	input  logic  inst_read_i,
	input  word_t inst_addr_i,
	input  logic  data_read_i,
	input  logic  data_write_i,
	input  word_t data_addr_i,
	input  word_t data_wr_i,
	input  word_t num_inst_i,
	input  word_t output_port_i,
	input  logic  is_halted_i,
	input  word_t exp_out1_i,
	input  word_t exp_out2_i,
	input  word_t exp_addr_i,
	input  word_t exp_count_i,
	output int    error_count_o,
	output int    check_count_o
);

	logic in_reset = 1'b0;
	logic halted_seen = 1'b0;
	word_t last_out = '0;
	word_t port_want;
	word_t next_pc = '0;
	int outs = 0;
	int stores = 0;
	int loads = 0;

	initial begin
		error_count_o = 0;
		check_count_o = 0;
	end

	task automatic check_word(input string what, input word_t got, input word_t exp_val);
		check_count_o++;
		if (got !== exp_val) begin
			error_count_o++;
			$display("Error %0t ns: %s is %h, expected %h", $time, what, got, exp_val);
		end
	endtask

	task automatic check_flag(input string what, input logic ok);
		check_count_o++;
		if (ok !== 1'b1) begin
			error_count_o++;
			$display("Error %0t ns: %s", $time, what);
		end
	endtask

	// DUT state during a cycle follows reset as seen at the last rising edge
	always @(posedge clk) begin
		in_reset <= !reset_n;
	end

	always @(negedge clk) begin
		if (in_reset) begin
			check_word("num_inst_o after reset", num_inst_i, '0);
			check_flag("is_halted_o high during reset", !is_halted_i);
			check_flag("inst_read_o high during reset", !inst_read_i);
			check_flag("data strobe active during reset", !(data_read_i || data_write_i));
			halted_seen = 1'b0;
			outs = 0;
			stores = 0;
			loads = 0;
			next_pc = '0;
			last_out = output_port_i;
		end else begin
			check_flag("data read and write strobes high together",
				!(data_read_i && data_write_i));
			// fetches walk the program in order, holds only pause them
			if (inst_read_i) begin
				check_word("inst_addr_o", inst_addr_i, next_pc);
				next_pc = next_pc + 16'd1;
			end
			if (data_read_i) begin
				loads++;
				check_word("load address", data_addr_i, exp_addr_i);
			end
			if (data_write_i) begin
				stores++;
				check_word("store address", data_addr_i, exp_addr_i);
				check_word("store data", data_wr_i, exp_out1_i);
			end
			if (output_port_i !== last_out) begin
				// a zero first result gives no visible first update
				port_want = (outs == 0 && exp_out1_i != '0) ? exp_out1_i : exp_out2_i;
				check_flag("output port changed after halt", !halted_seen);
				check_flag("more than two output port updates", outs < 2);
				check_word("output_port_o", output_port_i, port_want);
				outs++;
			end
			if (is_halted_i && !halted_seen) begin
				check_word("num_inst_o at halt", num_inst_i, exp_count_i);
				check_word("output_port_o at halt", output_port_i, exp_out2_i);
				check_flag("not exactly one store before halt", stores == 1);
				check_flag("not exactly one load before halt", loads == 1);
			end
			check_flag("is_halted_o dropped without reset", !halted_seen || is_halted_i);
			check_flag("inst_read_o high while halted", !(is_halted_i && inst_read_i));
			halted_seen = halted_seen | is_halted_i;
			last_out = output_port_i;
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

	localparam int ROWS = 8;
	localparam int PROG_LEN = 11;
	localparam int RST_CYCLES = 5;
	localparam int WATCH_CYCLES = 4;
	// pipeline fill, the load-use bubble, drain and halt latency
	localparam int PIPE_SLACK = 12;
	localparam int CYCLE_LIMIT = ROWS * (RST_CYCLES + PROG_LEN + PIPE_SLACK + WATCH_CYCLES);
	localparam logic [7:0] STORE_OFF = 8'h85;

	logic clk;
	logic reset_n;
	logic inst_read;
	word_t inst_addr;
	word_t inst_data;
	logic data_read;
	logic data_write;
	word_t data_addr;
	word_t data_wr;
	word_t data_rd;
	word_t num_inst;
	word_t output_port;
	logic is_halted;

	word_t imem [65536];
	word_t dmem [65536];

	logic [5:0] row_func [ROWS];
	word_t row_a [ROWS];
	word_t row_b [ROWS];
	word_t row_out1 [ROWS];
	word_t row_out2 [ROWS];
	word_t row_count [ROWS];

	word_t exp_out1;
	word_t exp_out2;
	word_t exp_addr;
	word_t exp_count;
	logic [31:0] lfsr_state;
	int cycles = 0;
	int error_count;
	int check_count;

	initial clk = 1'b0;
	always #4 clk = ~clk;

	cpu_top dut0 (
		.clk           (clk),
		.reset_n       (reset_n),
		.inst_read_o   (inst_read),
		.inst_addr_o   (inst_addr),
		.inst_data_i   (inst_data),
		.data_read_o   (data_read),
		.data_write_o  (data_write),
		.data_addr_o   (data_addr),
		.data_wr_o     (data_wr),
		.data_rd_i     (data_rd),
		.num_inst_o    (num_inst),
		.output_port_o (output_port),
		.is_halted_o   (is_halted)
	);

	bind cpu_top cpu_sva sva0 (
		.clk          (clk),
		.reset_n      (reset_n),
		.inst_read_i  (inst_read_o),
		.data_read_i  (data_read_o),
		.data_write_i (data_write_o),
		.num_inst_i   (num_inst_o),
		.is_halted_i  (is_halted_o)
	);

	cpu_checker chk0 (
		.clk           (clk),
		.reset_n       (reset_n),
		.inst_read_i   (inst_read),
		.inst_addr_i   (inst_addr),
		.data_read_i   (data_read),
		.data_write_i  (data_write),
		.data_addr_i   (data_addr),
		.data_wr_i     (data_wr),
		.num_inst_i    (num_inst),
		.output_port_i (output_port),
		.is_halted_i   (is_halted),
		.exp_out1_i    (exp_out1),
		.exp_out2_i    (exp_out2),
		.exp_addr_i    (exp_addr),
		.exp_count_i   (exp_count),
		.error_count_o (error_count),
		.check_count_o (check_count)
	);

	// both memories answer in the same cycle
	assign inst_data = imem[inst_addr];
	assign data_rd = dmem[data_addr];

	always @(negedge clk) begin
		if (data_write) begin
			dmem[data_addr] = data_wr;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the CPU did not halt within %0d cycles", CYCLE_LIMIT);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_word(output word_t w);
		w = '0;
		for (int i = 0; i < 16; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			w = {w[14:0], lfsr_state[0]};
		end
	endtask

	function automatic word_t alu_model(input logic [5:0] func, input word_t a, input word_t b);
		case (func)
			FN_ADD: return a + b;
			FN_SUB: return a - b;
			FN_AND: return a & b;
			FN_ORR: return a | b;
			FN_NOT: return ~a;
			FN_TCP: return 16'd0 - a;
			FN_SHL: return a << 1;
			FN_SHR: return word_t'($signed(a) >>> 1);
			default: return '0;
		endcase
	endfunction

	function automatic word_t enc_i(input logic [3:0] op, input reg_idx_t rs,
		input reg_idx_t rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t enc_r(input reg_idx_t rs, input reg_idx_t rt,
		input reg_idx_t rd, input logic [5:0] func);
		return {OP_RTYPE, rs, rt, rd, func};
	endfunction

	task automatic init_memories();
		for (int i = 0; i < 65536; i++) begin
			// odd multiplier makes every address bit show in the word
			imem[i] = (word_t'(i) * 16'h9e37) ^ 16'h3c5a;
			dmem[i] = ~word_t'(i);
		end
	endtask

	// r3 stays zero and serves as the memory base
	task automatic write_program(input int r);
		imem[0] = enc_i(OP_LHI, 2'd0, 2'd0, row_a[r][15:8]);
		imem[1] = enc_i(OP_ORI, 2'd0, 2'd0, row_a[r][7:0]);
		imem[2] = enc_i(OP_LHI, 2'd0, 2'd1, row_b[r][15:8]);
		imem[3] = enc_i(OP_ORI, 2'd1, 2'd1, row_b[r][7:0]);
		imem[4] = enc_r(2'd0, 2'd1, 2'd2, row_func[r]);
		imem[5] = enc_r(2'd2, 2'd0, 2'd0, FN_WWD);
		imem[6] = enc_i(OP_SWD, 2'd3, 2'd2, STORE_OFF);
		imem[7] = enc_i(OP_LWD, 2'd3, 2'd1, STORE_OFF);
		imem[8] = enc_i(OP_ADI, 2'd1, 2'd1, 8'd1);
		imem[9] = enc_r(2'd1, 2'd0, 2'd0, FN_WWD);
		imem[10] = enc_r(2'd0, 2'd0, 2'd0, FN_HLT);
	endtask

	initial begin
		reset_n = 1'b0;
		exp_out1 = '0;
		exp_out2 = '0;
		exp_addr = '0;
		exp_count = '0;
		lfsr_state = 32'hf58d_a754;
		init_memories();
		// func codes 0..7 are the eight ALU operations
		for (int r = 0; r < ROWS; r++) begin
			row_func[r] = 6'(r);
			draw_word(row_a[r]);
			draw_word(row_b[r]);
			row_out1[r] = alu_model(row_func[r], row_a[r], row_b[r]);
			row_out2[r] = row_out1[r] + 16'd1;
			row_count[r] = word_t'(PROG_LEN);
		end
		for (int r = 0; r < ROWS; r++) begin
			@(negedge clk);
			reset_n = 1'b0;
			exp_out1 = row_out1[r];
			exp_out2 = row_out2[r];
			exp_addr = {{8{STORE_OFF[7]}}, STORE_OFF};
			exp_count = row_count[r];
			init_memories();
			write_program(r);
			repeat (RST_CYCLES) @(negedge clk);
			reset_n = 1'b1;
			while (!is_halted) @(negedge clk);
			// stay a few cycles to watch the halted core
			repeat (WATCH_CYCLES) @(negedge clk);
		end
		$display("checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/register_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/cpu_top.sv
tests/cpu_sva.sv
tests/cpu_checker.sv
tests/tb_cpu.sv
